//--- logic/c64_load_pkg.sv
/*
 * Shared types and constants for the program file loader.
 * Covers the byte and address widths, the BASIC pointer map and the loader FSM states.
 */
package c64_load_pkg;

	// ==================================================
	// Data and address widths
	// ==================================================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] mem_addr_t;

	// Byte offset inside the downloaded file
	typedef logic [15:0] xfer_addr_t;

	// Loader FSM
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_DATA,
		LD_PATCH
	} loader_state_t;

	// Little-endian load address header
	localparam xfer_addr_t PRG_HDR_BYTES = 16'd2;

	// ==================================================
	// BASIC pointers in zero page
	// ==================================================
	// Low byte address of each pair, high byte follows
	localparam mem_addr_t ZP_TXTTAB     = 16'h002B;
	localparam mem_addr_t ZP_VARTAB     = 16'h002D;
	localparam mem_addr_t ZP_ARYTAB     = 16'h002F;
	localparam mem_addr_t ZP_STREND     = 16'h0031;
	localparam mem_addr_t ZP_SAVE_START = 16'h00AC;
	localparam mem_addr_t ZP_LOAD_END   = 16'h00AE;

	// Patch walk covers the whole zero page
	localparam mem_addr_t PATCH_LIMIT   = 16'h0100;

endpackage

//--- logic/prg_loader.sv
/*
 * Program file loader. Takes the load address from the header, turns payload
 * bytes into memory write requests and patches the BASIC pointers at the end.
 */
`timescale 1ns/10ps

module prg_loader
	import c64_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       ioctl_download_i,
	input  logic       ioctl_wr_i,
	input  xfer_addr_t ioctl_addr_i,
	input  byte_t      ioctl_data_i,
	input  logic       pending_i,
	output logic       req_o,
	output mem_addr_t  req_addr_o,
	output byte_t      req_data_o,
	output logic       load_done_o
);

	loader_state_t state;
	logic          download_d;
	logic          download_fall;
	mem_addr_t     start_addr;
	mem_addr_t     end_addr;
	mem_addr_t     walk_addr;
	logic          patch_wrote;
	logic          ptr_hit;
	byte_t         ptr_byte;
	logic          host_strobe;
	logic          payload_strobe;
	logic          patch_idle;
	logic          patch_write;
	logic          patch_skip;
	logic          patch_end;

	assign download_fall  = download_d & ~ioctl_download_i;
	assign host_strobe    = ioctl_wr_i & ioctl_download_i & (state != LD_PATCH);
	assign payload_strobe = host_strobe & (ioctl_addr_i >= PRG_HDR_BYTES);

	// Walk only moves once the last write has left the slot
	assign patch_idle  = (state == LD_PATCH) & ~req_o & ~pending_i;
	assign patch_end   = patch_idle & (walk_addr == PATCH_LIMIT);
	assign patch_write = patch_idle & ~patch_end & ptr_hit & ~patch_wrote;
	assign patch_skip  = patch_idle & ~patch_end & ~patch_write;

	// ==================================================
	// Pointer byte for the current walk address
	// ==================================================
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_byte = start_addr[7:0];
		case (walk_addr)
			ZP_TXTTAB,
			ZP_SAVE_START:
				ptr_byte = start_addr[7:0];
			ZP_TXTTAB + 16'd1,
			ZP_SAVE_START + 16'd1:
				ptr_byte = start_addr[15:8];
			// Variables, arrays and strings all start right after the program
			ZP_VARTAB,
			ZP_ARYTAB,
			ZP_STREND,
			ZP_LOAD_END:
				ptr_byte = end_addr[7:0];
			ZP_VARTAB + 16'd1,
			ZP_ARYTAB + 16'd1,
			ZP_STREND + 16'd1,
			ZP_LOAD_END + 16'd1:
				ptr_byte = end_addr[15:8];
			default:
				ptr_hit = 1'b0;
		endcase
	end

	// ==================================================
	// Loader FSM
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state       <= LD_IDLE;
			download_d  <= 1'b0;
			req_o       <= 1'b0;
			load_done_o <= 1'b0;
			patch_wrote <= 1'b0;
		end else begin
			download_d  <= ioctl_download_i;
			req_o       <= payload_strobe | patch_write;
			load_done_o <= 1'b0;

			case (state)
				LD_IDLE: begin
					if (ioctl_download_i)
						state <= LD_DATA;
				end
				LD_DATA: begin
					if (download_fall) begin
						state       <= LD_PATCH;
						patch_wrote <= 1'b0;
					end
				end
				LD_PATCH: begin
					if (patch_end) begin
						load_done_o <= 1'b1;
						state       <= LD_IDLE;
					end else if (patch_write) begin
						patch_wrote <= 1'b1;
					end else if (patch_skip) begin
						patch_wrote <= 1'b0;
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

	// Address and data path
	always_ff @(posedge clk_sys) begin
		if (host_strobe) begin
			if (ioctl_addr_i < PRG_HDR_BYTES) begin
				// Header byte 0 is the low half, byte 1 the high half
				if (ioctl_addr_i[0]) begin
					start_addr[15:8] <= ioctl_data_i;
					end_addr[15:8]   <= ioctl_data_i;
				end else begin
					start_addr[7:0] <= ioctl_data_i;
					end_addr[7:0]   <= ioctl_data_i;
				end
			end else begin
				// Running address doubles as the end pointer
				req_addr_o <= end_addr;
				req_data_o <= ioctl_data_i;
				end_addr   <= end_addr + 16'd1;
			end
		end

		if (state == LD_DATA && download_fall)
			walk_addr <= '0;

		if (patch_write) begin
			req_addr_o <= walk_addr;
			req_data_o <= ptr_byte;
		end

		if (patch_skip)
			walk_addr <= walk_addr + 16'd1;
	end

endmodule

//--- logic/mem_write_slot.sv
/*
 * Memory write slot. Holds one pending write and issues it in the shared slot
 * that follows the next falling edge of the slot marker.
 */
`timescale 1ns/10ps

module mem_write_slot
	import c64_load_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      req_i,
	input  mem_addr_t req_addr_i,
	input  byte_t     req_data_i,
	input  logic      mem_slot_i,
	output logic      pending_o,
	output logic      mem_we_o,
	output mem_addr_t mem_addr_o,
	output byte_t     mem_data_o
);

	logic slot_d;
	logic slot_fall;
	logic slot_second;
	logic launch;
	logic retire;

	// Slot edges from the delayed copy
	assign slot_fall   = slot_d & ~mem_slot_i;
	assign slot_second = slot_d & mem_slot_i;

	// Launch on the fall, retire in the second cycle of the next slot
	assign launch = slot_fall & pending_o & ~mem_we_o;
	assign retire = slot_second & mem_we_o;

	// ==================================================
	// Slot control
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d    <= 1'b0;
			pending_o <= 1'b0;
			mem_we_o  <= 1'b0;
		end else begin
			slot_d <= mem_slot_i;

			if (req_i)
				pending_o <= 1'b1;
			else if (retire)
				pending_o <= 1'b0;

			if (launch)
				mem_we_o <= 1'b1;
			else if (retire)
				mem_we_o <= 1'b0;
		end
	end

	// Request payload stays stable until the write retires
	always_ff @(posedge clk_sys) begin
		if (req_i) begin
			mem_addr_o <= req_addr_i;
			mem_data_o <= req_data_i;
		end
	end

endmodule

//--- logic/c64_prg_inject.sv
/*
 * Program injection top level. Loader stage feeds the memory write slot stage.
 */
`timescale 1ns/10ps

module c64_prg_inject
	import c64_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       ioctl_download_i,
	input  logic       ioctl_wr_i,
	input  xfer_addr_t ioctl_addr_i,
	input  byte_t      ioctl_data_i,
	input  logic       mem_slot_i,
	output logic       ioctl_wait_o,
	output logic       mem_we_o,
	output mem_addr_t  mem_addr_o,
	output byte_t      mem_data_o,
	output logic       load_done_o
);

	// Loader to slot
	logic      req;
	mem_addr_t req_addr;
	byte_t     req_data;
	logic      pending;

	// Host stalls for as long as a write is held
	assign ioctl_wait_o = pending;

	prg_loader u_loader (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.pending_i        (pending),
		.req_o            (req),
		.req_addr_o       (req_addr),
		.req_data_o       (req_data),
		.load_done_o      (load_done_o)
	);

	mem_write_slot u_slot (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.req_i      (req),
		.req_addr_i (req_addr),
		.req_data_i (req_data),
		.mem_slot_i (mem_slot_i),
		.pending_o  (pending),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

//--- dv/c64_prg_inject_asserts.sv
/*
 * Protocol assertions for the program injection top level.
 */
`timescale 1ns/10ps

module c64_prg_inject_asserts
	import c64_load_pkg::*;
(
	input logic       clk_sys,
	input logic       reset_n,
	input logic       ioctl_download_i,
	input logic       ioctl_wr_i,
	input xfer_addr_t ioctl_addr_i,
	input logic       mem_slot_i,
	input logic       ioctl_wait_i,
	input logic       mem_we_i,
	input logic       load_done_i
);

	int unsigned fail_count = 0;
	logic        download_d;
	logic        done_armed;
	logic        payload_strobe;

	assign payload_strobe = ioctl_wr_i & ioctl_download_i & (ioctl_addr_i >= PRG_HDR_BYTES);

	task automatic flag_failure(input string what);
		fail_count = fail_count + 1;
		$error("%s", what);
	endtask

	// Armed by the end of a download, cleared by its done pulse
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			download_d <= 1'b0;
			done_armed <= 1'b0;
		end else begin
			download_d <= ioctl_download_i;
			if (download_d && !ioctl_download_i)
				done_armed <= 1'b1;
			else if (load_done_i)
				done_armed <= 1'b0;
		end
	end

	// ==================================================
	// Properties
	// ==================================================
	reset_quiet: assert property (@(posedge clk_sys)
		!reset_n |=> (!mem_we_i && !ioctl_wait_i && !load_done_i))
		else flag_failure("mem_we, ioctl_wait or load_done active after reset");

	// Write launched on the cycle after the slot falls
	we_launch: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(mem_we_i) |-> (!$past(mem_slot_i) && $past(mem_slot_i, 2)))
		else flag_failure("mem_we rose without a preceding slot fall");

	// Retired after two slot cycles with the write present
	we_retire: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$fell(mem_we_i) |-> ($past(mem_slot_i) && $past(mem_slot_i, 2) && $past(mem_we_i, 2)))
		else flag_failure("mem_we dropped outside the second slot cycle");

	no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ioctl_wr_i |-> !ioctl_wait_i)
		else flag_failure("host strobe arrived while ioctl_wait was high");

	wait_after_payload: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$past(payload_strobe, 2) |-> ioctl_wait_i)
		else flag_failure("ioctl_wait not raised after a payload byte");

	wait_ends_with_write: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$fell(ioctl_wait_i) |-> $fell(mem_we_i))
		else flag_failure("ioctl_wait dropped before the write retired");

	done_once: assert property (@(posedge clk_sys) disable iff (!reset_n)
		load_done_i |-> (done_armed && !ioctl_wait_i && !mem_we_i))
		else flag_failure("load_done pulsed twice or with a write still in flight");

endmodule

bind c64_prg_inject c64_prg_inject_asserts u_asserts (
	.clk_sys          (clk_sys),
	.reset_n          (reset_n),
	.ioctl_download_i (ioctl_download_i),
	.ioctl_wr_i       (ioctl_wr_i),
	.ioctl_addr_i     (ioctl_addr_i),
	.mem_slot_i       (mem_slot_i),
	.ioctl_wait_i     (ioctl_wait_o),
	.mem_we_i         (mem_we_o),
	.load_done_i      (load_done_o)
);

//--- dv/c64_prg_inject_tb.sv
/*
 * Testbench for the program injection top level. Streams two program files
 * through the host port and checks payload and BASIC pointers in a memory model.
 */
`timescale 1ns/10ps

module c64_prg_inject_tb
	import c64_load_pkg::*;
();

	localparam int WAIT_LIMIT = 64;
	localparam int DONE_LIMIT = 4000;

	logic        clk_sys;
	logic        reset_n;
	logic        ioctl_download_i;
	logic        ioctl_wr_i;
	xfer_addr_t  ioctl_addr_i;
	byte_t       ioctl_data_i;
	logic        mem_slot_i;
	logic        ioctl_wait_o;
	logic        mem_we_o;
	mem_addr_t   mem_addr_o;
	byte_t       mem_data_o;
	logic        load_done_o;

	integer      seed;
	int          tb_errors;
	int          done_count;
	logic [2:0]  slot_cnt;
	logic [16:0] fill_addr;
	byte_t       model_mem [0:65535];
	byte_t       payload [0:255];

	c64_prg_inject i_c64_prg_inject (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.mem_slot_i       (mem_slot_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.load_done_o      (load_done_o)
	);

	always #10 clk_sys = ~clk_sys;

	// ==================================================
	// Slot pattern and memory model
	// ==================================================
	always @(posedge clk_sys) begin
		if (!reset_n) begin
			// Background pattern so an unwritten byte never matches
			for (fill_addr = '0; fill_addr < 17'h10000; fill_addr = fill_addr + 17'd1)
				model_mem[fill_addr[15:0]] <= fill_addr[7:0] ^ fill_addr[15:8] ^ 8'hA5;
			slot_cnt   <= '0;
			done_count <= 0;
		end else begin
			// 3 cycles high, 5 low
			slot_cnt   <= slot_cnt + 3'd1;
			mem_slot_i <= (slot_cnt < 3'd3);
			if (mem_we_o)
				model_mem[mem_addr_o] <= mem_data_o;
			if (load_done_o)
				done_count <= done_count + 1;
		end
	end

	task automatic check_value(input string test, input byte_t expected, input byte_t actual);
		if (actual !== expected) begin
			tb_errors++;
			$display("** Error: %s expected %02h actual %02h", test, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		tb_errors++;
		$display("Timeout: %s did not happen in time", what);
	endtask

	// Steps clock edges until ioctl_wait_o reaches the level
	task automatic wait_for_wait(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (ioctl_wait_o !== level && cycles < WAIT_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (ioctl_wait_o !== level)
			report_timeout(what);
	endtask

	task automatic send_byte(input xfer_addr_t offset, input byte_t value);
		wait_for_wait(1'b0, "host port ready");
		ioctl_wr_i   <= 1'b1;
		ioctl_addr_i <= offset;
		ioctl_data_i <= value;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		// Payload bytes hold the host until the write leaves the slot
		if (offset >= PRG_HDR_BYTES) begin
			wait_for_wait(1'b1, "ioctl_wait_o rise after a payload byte");
			wait_for_wait(1'b0, "ioctl_wait_o fall after a memory write");
		end
	endtask

	task automatic check_pointer(input string tag, input string name, input mem_addr_t zp,
		input mem_addr_t expected);
		check_value({tag, " ", name, " low"}, expected[7:0], model_mem[zp]);
		check_value({tag, " ", name, " high"}, expected[15:8], model_mem[zp + 16'd1]);
	endtask

	// ==================================================
	// One program file download and its checks
	// ==================================================
	task automatic load_file(input string tag, input mem_addr_t load_addr, input int len,
		input int expected_done);
		mem_addr_t end_addr;
		int        n;
		int        cycles;
		for (n = 0; n < len; n++)
			payload[n] = byte_t'($random(seed));
		ioctl_download_i <= 1'b1;
		send_byte(16'd0, load_addr[7:0]);
		send_byte(16'd1, load_addr[15:8]);
		for (n = 0; n < len; n++)
			send_byte(PRG_HDR_BYTES + xfer_addr_t'(n), payload[n]);
		ioctl_download_i <= 1'b0;

		// Patch walk covers the zero page before the done pulse
		cycles = 0;
		while (!load_done_o && cycles < DONE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (!load_done_o)
			report_timeout({tag, " load_done_o pulse"});
		@(posedge clk_sys);

		for (n = 0; n < len; n++)
			check_value($sformatf("%s payload byte %0d", tag, n), payload[n],
				model_mem[load_addr + mem_addr_t'(n)]);
		end_addr = load_addr + mem_addr_t'(len);
		check_pointer(tag, "TXTTAB", ZP_TXTTAB, load_addr);
		check_pointer(tag, "SAVE_START", ZP_SAVE_START, load_addr);
		check_pointer(tag, "VARTAB", ZP_VARTAB, end_addr);
		check_pointer(tag, "ARYTAB", ZP_ARYTAB, end_addr);
		check_pointer(tag, "STREND", ZP_STREND, end_addr);
		check_pointer(tag, "LOAD_END", ZP_LOAD_END, end_addr);
		check_value({tag, " load_done_o pulse count"}, byte_t'(expected_done),
			byte_t'(done_count));
	endtask

	initial begin
		clk_sys          = 1'b0;
		reset_n          <= 1'b0;
		ioctl_download_i <= 1'b0;
		ioctl_wr_i       <= 1'b0;
		ioctl_addr_i     <= '0;
		ioctl_data_i     <= '0;
		mem_slot_i       <= 1'b0;
		seed             = 564;
		tb_errors        = 0;

		repeat (4) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(posedge clk_sys);

		load_file("load_0801", 16'h0801, 40, 1);
		load_file("load_c000", 16'hC000, 24, 2);
		@(posedge clk_sys);

		$display("Result: %0d testbench errors, %0d assertion failures",
			tb_errors, i_c64_prg_inject.u_asserts.fail_count);
		if (tb_errors == 0 && i_c64_prg_inject.u_asserts.fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- c64_prg_inject.f
logic/c64_load_pkg.sv
logic/prg_loader.sv
logic/mem_write_slot.sv
logic/c64_prg_inject.sv
dv/c64_prg_inject_asserts.sv
dv/c64_prg_inject_tb.sv

//--- Makefile
# Verilator simulation of the program injection core
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := c64_prg_inject_tb
FILELIST  := c64_prg_inject.f
BUILD_DIR := obj_dir
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails unless it passes"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
